/* verilog/pwrEventPkg.sv */
package pwrEventPkg;

    // --------------------
    // Event states
    // --------------------
    // Codes 5, 6 and 10 up are unused and recover to standby
    typedef enum logic [3:0] {
        InitPowerUp  = 4'd0,    // Read stored bit after reset
        PowerStandBy = 4'd1,    // Off, waiting for the button
        Reboot       = 4'd2,    // Supply on, waiting for power good
        UpdatePwrSt  = 4'd3,    // Record running state
        SystemRun    = 4'd4,
        PowerFail    = 4'd7,    // ATX dropped while running
        Wait2s       = 4'd8,    // Settle before standby
        PowerDown    = 9        // Software off request
    } evtState_t;

    // Elapsed time in ms
    typedef logic [15:0] msCount_t;

    // Flash sequence kinds
    typedef enum logic {
        PromRead        = 1'b0,
        PromWriteVerify = 1'b1  // Erase and program, then read back
    } promOp_t;

    // --------------------
    // Intervals in ms
    // --------------------
    localparam msCount_t EvtT20   = 16'd20;
    localparam msCount_t EvtT30   = 16'd30;
    localparam msCount_t EvtT100  = 16'd100;
    localparam msCount_t EvtT1020 = 16'd1020;  // Write strobe end
    localparam msCount_t EvtT1030 = 16'd1030;  // Readback start
    localparam msCount_t EvtT1040 = 16'd1040;
    localparam msCount_t EvtT1050 = 16'd1050;  // Write-verify done
    localparam msCount_t EvtT5000 = 16'd5000;
    localparam msCount_t EvtT6000 = 16'd6000;
    localparam msCount_t EvtT8000 = 16'd8000;

    // Pin and flash levels
    localparam logic PwrStateOk    = 1'b1;  // Last shutdown was orderly
    localparam logic PwrStateFail  = 1'b0;  // Was running when power went
    localparam logic ButtonPress   = 1'b0;
    localparam logic ButtonRelease = 1'b1;
    localparam logic PwrSwOn       = 1'b0;  // PS_ONn is active low
    localparam logic PwrSwOff      = 1'b1;

endpackage

/* verilog/msTimer.sv */
`timescale 1ns/1ns

module msTimer #(
    parameter int CyclesPerMs = 33
) (
    input  logic                  CLK32768,
    input  logic                  ResetN,
    input  logic                  Restart,
    output pwrEventPkg::msCount_t ElapsedMs
);
    import pwrEventPkg::*;

    localparam int       DivW  = $clog2(CyclesPerMs);
    localparam msCount_t MsMax = '1;    // Saturation value

    logic [DivW-1:0] divCnt;    // Cycle within the current ms
    logic            msTick;    // Last cycle of a ms

    assign msTick = (divCnt == DivW'(CyclesPerMs - 1));

    // --------------------
    // Cycle divider
    // --------------------
    always_ff @(posedge CLK32768 or negedge ResetN) begin
        if (!ResetN) begin
            divCnt <= '0;
        end else if (Restart || msTick) begin
            divCnt <= '0;   // Realign to the starting event
        end else begin
            divCnt <= divCnt + 1'b1;
        end
    end

    // --------------------
    // Millisecond count
    // --------------------
    always_ff @(posedge CLK32768 or negedge ResetN) begin
        if (!ResetN) begin
            ElapsedMs <= '0;
        end else if (Restart) begin
            ElapsedMs <= '0;
        end else if (msTick && (ElapsedMs != MsMax)) begin
            ElapsedMs <= ElapsedMs + 1'b1;  // Holds at max, no wrap
        end
    end

endmodule

/* verilog/promSequencer.sv */
`timescale 1ns/1ns

module promSequencer #(
    parameter int CyclesPerMs = 33
) (
    input  logic                 CLK32768,
    input  logic                 ResetN,
    input  logic                 PromStart,
    input  pwrEventPkg::promOp_t PromOp,
    input  logic                 PromWrBit,
    output logic                 PromCreditReturn,
    output logic                 bFlashPromReq,
    output logic                 bWrPromCfg,
    output logic                 bRdPromCfg,
    output logic                 PwrLastStateWrBit,
    input  logic                 PwrLastStateRdBit
);
    import pwrEventPkg::*;

    promOp_t  opQ;          // Operation of the running sequence
    msCount_t elapsedMs;    // Time since PromStart
    msCount_t rdOn;         // Readback window start
    msCount_t rdOff;
    msCount_t seqEnd;
    logic     seqDone;      // First cycle of the end time

    // Timer starts with the sequence
    msTimer #(
        .CyclesPerMs(CyclesPerMs)
    ) seqTimer (
        .CLK32768 (CLK32768),
        .ResetN   (ResetN),
        .Restart  (PromStart),
        .ElapsedMs(elapsedMs)
    );

    // --------------------
    // Strobe windows
    // --------------------
    always_comb begin
        if (opQ == PromWriteVerify) begin
            rdOn   = EvtT1030;  // Erase and program time first
            rdOff  = EvtT1040;
            seqEnd = EvtT1050;
        end else begin
            rdOn   = EvtT20;
            rdOff  = EvtT30;
            seqEnd = EvtT100;
        end
    end

    // Program strobe only for write-verify
    assign bWrPromCfg = bFlashPromReq && (opQ == PromWriteVerify) &&
                        (elapsedMs >= EvtT20) && (elapsedMs < EvtT1020);
    assign bRdPromCfg = bFlashPromReq && (elapsedMs >= rdOn) && (elapsedMs < rdOff);
    assign seqDone    = bFlashPromReq && (elapsedMs == seqEnd);

    // Operation latch
    always_ff @(posedge CLK32768) begin
        if (PromStart) begin
            opQ <= PromOp;
        end
    end

    // --------------------
    // Request, bit and credit
    // --------------------
    always_ff @(posedge CLK32768 or negedge ResetN) begin
        if (!ResetN) begin
            bFlashPromReq     <= 1'b0;
            PromCreditReturn  <= 1'b0;
            PwrLastStateWrBit <= PwrStateOk;
        end else begin
            PromCreditReturn <= seqDone;    // Single pulse, busy drops with it
            if (PromStart) begin
                bFlashPromReq <= 1'b1;
                if (PromOp == PromWriteVerify) begin
                    PwrLastStateWrBit <= PromWrBit;     // Value being programmed
                end
            end else if (seqDone) begin
                bFlashPromReq     <= 1'b0;
                PwrLastStateWrBit <= PwrLastStateRdBit; // Adopt what flash holds
            end
        end
    end

    // --------------------
    // Assertions
    // --------------------
    // FSM must wait for the credit before starting again
    aNoStartBusy: assert property (@(posedge CLK32768) disable iff (!ResetN)
        PromStart |-> !bFlashPromReq)
        else $error("promSequencer: PromStart while a sequence is running");

    // Program and read windows never overlap
    aStrobeExcl: assert property (@(posedge CLK32768) disable iff (!ResetN)
        !(bWrPromCfg && bRdPromCfg))
        else $error("promSequencer: bWrPromCfg and bRdPromCfg high together");

endmodule

/* verilog/pwrEventFsm.sv */
`timescale 1ns/1ns

module pwrEventFsm #(
    parameter int CyclesPerMs = 33
) (
    input  logic                   CLK32768,
    input  logic                   ResetN,
    input  logic                   PowerbuttonIn,
    input  logic                   ATX_PowerOK,
    input  logic                   ALL_PWRGD,
    input  logic                   PowerOff,
    input  logic                   PwrLastStateWrBit,
    input  logic                   PromCreditReturn,
    output logic                   PromStart,
    output logic                   PromWrBit,
    output pwrEventPkg::promOp_t   PromOp,
    output logic                   PS_ONn,
    output logic                   PowerbuttonEvtOut,
    output pwrEventPkg::evtState_t PowerEvtState
);
    import pwrEventPkg::*;

    evtState_t nextState;
    msCount_t  elapsedMs;       // Time in current state
    logic      stateChange;
    logic      timerRestart;
    logic      creditAvail;     // The single flash credit
    logic      reqIssued;       // This state already started its sequence
    logic      startReq;
    promOp_t   opReq;
    logic      wrBitReq;
    logic      psOnNext;
    logic      buttonNext;
    logic      pwrGood;

    assign pwrGood     = ATX_PowerOK && ALL_PWRGD;
    assign stateChange = (nextState != PowerEvtState);

    // Button release in standby restarts the debounce
    assign timerRestart = stateChange ||
                          ((PowerEvtState == PowerStandBy) && (PowerbuttonIn == ButtonRelease));

    msTimer #(
        .CyclesPerMs(CyclesPerMs)
    ) evtTimer (
        .CLK32768 (CLK32768),
        .ResetN   (ResetN),
        .Restart  (timerRestart),
        .ElapsedMs(elapsedMs)
    );

    // --------------------
    // Next state and outputs
    // --------------------
    always_comb begin
        nextState  = PowerEvtState;
        psOnNext   = PwrSwOff;      // Supply off unless a state wants it
        buttonNext = ButtonRelease;
        startReq   = 1'b0;
        opReq      = PromRead;
        wrBitReq   = PwrStateOk;
        case (PowerEvtState)
            InitPowerUp: begin
                startReq = creditAvail && !reqIssued;   // Read the stored bit
                if (reqIssued && PromCreditReturn) begin
                    // Fail means power was lost while running
                    nextState = (PwrLastStateWrBit == PwrStateOk) ? PowerStandBy : Reboot;
                end
            end
            PowerStandBy: begin
                if ((PowerbuttonIn == ButtonPress) && (elapsedMs > EvtT20))
                    nextState = Reboot;     // Debounced press
            end
            Reboot: begin
                psOnNext = PwrSwOn;
                if (pwrGood)
                    nextState = UpdatePwrSt;
                else if (elapsedMs >= EvtT5000)
                    nextState = Wait2s;     // Power good timeout
            end
            UpdatePwrSt: begin
                psOnNext = PwrSwOn;
                startReq = creditAvail && !reqIssued;
                opReq    = PromWriteVerify;
                wrBitReq = PwrStateFail;    // Marks "running" in flash
                if (reqIssued && PromCreditReturn)
                    nextState = pwrGood ? SystemRun : Wait2s;
            end
            SystemRun: begin
                psOnNext = PwrSwOn;
                if (PowerOff)
                    nextState = PowerDown;
                else if (!ATX_PowerOK)
                    nextState = PowerFail;
            end
            PowerFail: begin
                if (elapsedMs >= EvtT5000)
                    nextState = Wait2s;
                else if (ATX_PowerOK)
                    nextState = Reboot;     // Supply came back in time
            end
            PowerDown: begin
                startReq = creditAvail && !reqIssued;
                opReq    = PromWriteVerify;
                wrBitReq = PwrStateOk;      // Orderly shutdown
                if (elapsedMs < EvtT5000)
                    buttonNext = ButtonPress;   // Hold button toward chipset
                if (elapsedMs < EvtT6000)
                    psOnNext = PwrSwOn;
                if (elapsedMs >= EvtT8000)
                    nextState = Wait2s;
            end
            Wait2s: begin
                if (elapsedMs > EvtT6000)
                    nextState = PowerStandBy;
            end
            default: begin
                nextState = PowerStandBy;   // Unused code
            end
        endcase
    end

    // --------------------
    // State, pins and credit
    // --------------------
    always_ff @(posedge CLK32768 or negedge ResetN) begin
        if (!ResetN) begin
            PowerEvtState     <= InitPowerUp;
            PS_ONn            <= PwrSwOff;
            PowerbuttonEvtOut <= ButtonRelease;
            PromStart         <= 1'b0;
            creditAvail       <= 1'b1;  // One credit after reset
            reqIssued         <= 1'b0;
        end else begin
            PowerEvtState     <= nextState;
            PS_ONn            <= psOnNext;
            PowerbuttonEvtOut <= buttonNext;
            PromStart         <= startReq;
            if (PromStart)
                creditAvail <= 1'b0;    // Spent
            else if (PromCreditReturn)
                creditAvail <= 1'b1;
            if (stateChange)
                reqIssued <= 1'b0;
            else if (startReq)
                reqIssued <= 1'b1;
        end
    end

    // Operation and bit for the sequencer, valid with PromStart
    always_ff @(posedge CLK32768) begin
        if (startReq) begin
            PromOp    <= opReq;
            PromWrBit <= wrBitReq;
        end
    end

    // --------------------
    // Assertions
    // --------------------
    aStartWithCredit: assert property (@(posedge CLK32768) disable iff (!ResetN)
        PromStart |-> creditAvail)
        else $error("pwrEventFsm: PromStart without a flash credit");

    // Sequencer returns only a credit that was handed out
    aReturnOnlyOut: assert property (@(posedge CLK32768) disable iff (!ResetN)
        PromCreditReturn |-> !creditAvail)
        else $error("pwrEventFsm: credit returned while already held");

endmodule

/* verilog/pwrEventTop.sv */
`timescale 1ns/1ns

module pwrEventTop #(
    parameter int CyclesPerMs = 33
) (
    input  logic                   CLK32768,
    input  logic                   ResetN,
    input  logic                   PowerbuttonIn,
    input  logic                   ATX_PowerOK,
    input  logic                   ALL_PWRGD,
    input  logic                   PowerOff,
    input  logic                   PwrLastStateRdBit,
    output logic                   PS_ONn,
    output logic                   PowerbuttonEvtOut,
    output pwrEventPkg::evtState_t PowerEvtState,
    output logic                   bFlashPromReq,
    output logic                   bWrPromCfg,
    output logic                   bRdPromCfg,
    output logic                   PwrLastStateWrBit
);
    import pwrEventPkg::*;

    // --------------------
    // Flash credit channel
    // --------------------
    logic    promStart;
    promOp_t promOp;
    logic    promWrBit;
    logic    promCreditReturn;

    pwrEventFsm #(
        .CyclesPerMs(CyclesPerMs)
    ) fsmInst (
        .CLK32768         (CLK32768),
        .ResetN           (ResetN),
        .PowerbuttonIn    (PowerbuttonIn),
        .ATX_PowerOK      (ATX_PowerOK),
        .ALL_PWRGD        (ALL_PWRGD),
        .PowerOff         (PowerOff),
        .PwrLastStateWrBit(PwrLastStateWrBit),  // Current stored value
        .PromCreditReturn (promCreditReturn),
        .PromStart        (promStart),
        .PromWrBit        (promWrBit),
        .PromOp           (promOp),
        .PS_ONn           (PS_ONn),
        .PowerbuttonEvtOut(PowerbuttonEvtOut),
        .PowerEvtState    (PowerEvtState)
    );

    promSequencer #(
        .CyclesPerMs(CyclesPerMs)
    ) seqInst (
        .CLK32768         (CLK32768),
        .ResetN           (ResetN),
        .PromStart        (promStart),
        .PromOp           (promOp),
        .PromWrBit        (promWrBit),
        .PromCreditReturn (promCreditReturn),
        .bFlashPromReq    (bFlashPromReq),
        .bWrPromCfg       (bWrPromCfg),
        .bRdPromCfg       (bRdPromCfg),
        .PwrLastStateWrBit(PwrLastStateWrBit),
        .PwrLastStateRdBit(PwrLastStateRdBit)
    );

endmodule

/* verification/pwrEventChecker.sv */
`timescale 1ns/1ns

module pwrEventChecker #(
    parameter int CyclesPerMs = 2
) (
    input  logic                   CLK32768,
    input  logic                   ResetN,
    input  logic                   bFlashPromReq,
    input  logic                   bWrPromCfg,
    input  logic                   bRdPromCfg,
    input  logic                   PS_ONn,
    input  pwrEventPkg::evtState_t PowerEvtState,
    output int                     errCount,
    output int                     rdPulses,
    output int                     wrPulses
);
    import pwrEventPkg::*;

    int        cyc;
    int        reqStart;    // Cycle of request rise
    int        wrRise;
    int        rdRise;
    int        pdCyc;       // Cycles spent in PowerDown
    logic      sawWr;
    logic      prevReq;
    logic      prevWr;
    logic      prevRd;
    logic      expPs;
    evtState_t lastState;   // State before the latest edge

    initial begin
        errCount = 0;
        rdPulses = 0;
        wrPulses = 0;
        cyc = 0;
    end

    // Compare a cycle count with a time in ms, one ms of slack
    task automatic checkMs(input string name, input int gotCyc, input int expMs);
        int diff;
        diff = gotCyc - expMs * CyclesPerMs;
        if (diff > CyclesPerMs || diff < -CyclesPerMs) begin
            $display("error at %0t: %s got %0d ms expected %0d ms",
                     $time, name, gotCyc / CyclesPerMs, expMs);
            errCount++;
        end
    endtask

    always @(posedge CLK32768) begin
        lastState <= ResetN ? PowerEvtState : InitPowerUp;
        pdCyc     <= (PowerEvtState == PowerDown) ? pdCyc + 1 : 0;
    end

    // --------------------
    // Flash strobes
    // --------------------
    always @(negedge CLK32768) begin
        cyc++;
        if (!ResetN) begin
            prevReq = 1'b0;
            prevWr  = 1'b0;
            prevRd  = 1'b0;
            sawWr   = 1'b0;
        end else begin
            if ((bWrPromCfg || bRdPromCfg) && !bFlashPromReq) begin
                $display("error at %0t: flash strobe high without bFlashPromReq", $time);
                errCount++;
            end
            if (bFlashPromReq && !prevReq) begin
                reqStart = cyc;
                sawWr    = 1'b0;
            end
            if (bWrPromCfg && !prevWr)
                wrRise = cyc;
            if (!bWrPromCfg && prevWr) begin
                wrPulses++;
                sawWr = 1'b1;
                checkMs("bWrPromCfg start", wrRise - reqStart, 20);
                checkMs("bWrPromCfg length", cyc - wrRise, 1000);
            end
            if (bRdPromCfg && !prevRd)
                rdRise = cyc;
            if (!bRdPromCfg && prevRd) begin
                rdPulses++;
                checkMs("bRdPromCfg start", rdRise - reqStart, sawWr ? 1030 : 20);
                checkMs("bRdPromCfg length", cyc - rdRise, 10);
            end
            if (!bFlashPromReq && prevReq)
                checkMs("bFlashPromReq length", cyc - reqStart, sawWr ? 1050 : 100);
            prevReq = bFlashPromReq;
            prevWr  = bWrPromCfg;
            prevRd  = bRdPromCfg;

            // --------------------
            // Supply switch
            // --------------------
            case (lastState)
                Reboot, UpdatePwrSt, SystemRun: expPs = PwrSwOn;
                PowerDown: begin
                    if (pdCyc < (6000 - 2) * CyclesPerMs)
                        expPs = PwrSwOn;
                    else if (pdCyc > (6000 + 2) * CyclesPerMs)
                        expPs = PwrSwOff;
                    else
                        expPs = PS_ONn;     // Near the switch-off edge
                end
                default: expPs = PwrSwOff;
            endcase
            if (PS_ONn !== expPs) begin
                $display("error at %0t: PS_ONn got %b expected %b", $time, PS_ONn, expPs);
                errCount++;
            end
        end
    end

endmodule

/* verification/tbPwrEvent.sv */
`timescale 1ns/1ns

module tbPwrEvent;
    import pwrEventPkg::*;

    localparam int CycMs = 2;   // Clock cycles per ms in this run

    logic      CLK32768;
    logic      ResetN;
    logic      PowerbuttonIn;
    logic      ATX_PowerOK;
    logic      ALL_PWRGD;
    logic      PowerOff;
    logic      PwrLastStateRdBit;
    logic      PS_ONn;
    logic      PowerbuttonEvtOut;
    evtState_t PowerEvtState;
    logic      bFlashPromReq;
    logic      bWrPromCfg;
    logic      bRdPromCfg;
    logic      PwrLastStateWrBit;

    logic        storedBit;     // Flash model contents
    logic [31:0] lfsr;
    int          scenErrors;
    int          chkErrors;
    int          rdPulses;
    int          wrPulses;
    int          rdBase;
    int          wrBase;
    int          holdMs;
    int          pressMs;
    int          onMs;          // Supply on time in Reboot

    pwrEventTop #(.CyclesPerMs(CycMs)) dut_i (.*);

    pwrEventChecker #(.CyclesPerMs(CycMs)) checkInst (
        .CLK32768(CLK32768), .ResetN(ResetN), .bFlashPromReq(bFlashPromReq),
        .bWrPromCfg(bWrPromCfg), .bRdPromCfg(bRdPromCfg), .PS_ONn(PS_ONn),
        .PowerEvtState(PowerEvtState), .errCount(chkErrors),
        .rdPulses(rdPulses), .wrPulses(wrPulses)
    );

    always #10 CLK32768 = ~CLK32768;    // 20 ns period

    // Flash model programs on the end of the write strobe
    always @(negedge bWrPromCfg) begin
        if (ResetN === 1'b1)
            storedBit <= PwrLastStateWrBit;
    end
    assign PwrLastStateRdBit = storedBit;

    // --------------------
    // Helpers
    // --------------------
    function automatic int randBits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha3000000) : (lfsr >> 1);   // Galois step
            r = (r << 1) | lfsr[0];
        end
        return r;
    endfunction

    task automatic tick();
        @(posedge CLK32768);
        #2;     // Drive and sample after the edge
    endtask

    task automatic idleMs(input int ms);
        for (int i = 0; i < ms * CycMs; i++)
            tick();
    endtask

    task automatic applyReset();
        ResetN = 1'b0;
        repeat (4) tick();
        ResetN = 1'b1;
    endtask

    task automatic waitState(input evtState_t exp, input int maxMs);
        int n;
        n = 0;
        while (PowerEvtState != exp && n < maxMs * CycMs) begin
            tick();
            n++;
        end
        if (PowerEvtState != exp) begin
            $display("timeout at %0t: state %s not reached in %0d ms, still %s",
                     $time, exp.name(), maxMs, PowerEvtState.name());
            scenErrors++;
        end
    endtask

    task automatic waitPs(input logic exp, input int maxMs);
        int n;
        n = 0;
        while (PS_ONn !== exp && n < maxMs * CycMs) begin
            tick();
            n++;
        end
        if (PS_ONn !== exp) begin
            $display("timeout at %0t: PS_ONn did not reach %b in %0d ms", $time, exp, maxMs);
            scenErrors++;
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
            scenErrors++;
        end
    endtask

    task automatic checkInt(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("error at %0t: %s got %0d expected %0d", $time, name, got, exp);
            scenErrors++;
        end
    endtask

    // Debounced press then run up to SystemRun
    task automatic pressToRun();
        holdMs = 30 + (randBits(6) % 61);
        PowerbuttonIn = ButtonPress;
        waitState(Reboot, 40);
        idleMs(holdMs - 20);
        PowerbuttonIn = ButtonRelease;
        waitState(SystemRun, 1200);
    endtask

    // --------------------
    // Scenarios
    // --------------------
    initial begin
        CLK32768 = 1'b0;
        ResetN = 1'b0;
        PowerbuttonIn = ButtonRelease;
        ATX_PowerOK = 1'b1;
        ALL_PWRGD = 1'b1;
        PowerOff = 1'b0;
        storedBit = PwrStateOk;
        lfsr = 32'hab36725b;
        scenErrors = 0;
        applyReset();

        // Clean boot reads only
        waitState(PowerStandBy, 200);
        checkInt("read pulses", rdPulses, 1);
        checkInt("write pulses", wrPulses, 0);
        checkBit("PS_ONn", PS_ONn, PwrSwOff);
        checkBit("PwrLastStateWrBit", PwrLastStateWrBit, PwrStateOk);

        // Button boot records running
        idleMs(10 + randBits(7));
        rdBase = rdPulses;
        wrBase = wrPulses;
        pressToRun();
        checkBit("PS_ONn", PS_ONn, PwrSwOn);
        checkBit("stored bit", storedBit, PwrStateFail);
        checkBit("PwrLastStateWrBit", PwrLastStateWrBit, PwrStateFail);
        checkInt("write pulses", wrPulses - wrBase, 1);
        checkInt("read pulses", rdPulses - rdBase, 1);

        // Software power down
        idleMs(10 + randBits(7));
        PowerOff = 1'b1;
        tick();
        PowerOff = 1'b0;
        waitState(PowerDown, 5);
        pressMs = 0;
        tick();
        while (PowerbuttonEvtOut === ButtonPress && pressMs < 6000 * CycMs) begin
            tick();
            pressMs++;
        end
        pressMs = pressMs / CycMs;
        if (pressMs < 4990 || pressMs > 5010) begin
            $display("error at %0t: PowerbuttonEvtOut low for %0d ms, expected 5000",
                     $time, pressMs);
            scenErrors++;
        end
        waitState(Wait2s, 4000);
        checkBit("PS_ONn", PS_ONn, PwrSwOff);
        checkBit("stored bit", storedBit, PwrStateOk);
        checkBit("PwrLastStateWrBit", PwrLastStateWrBit, PwrStateOk);
        waitState(PowerStandBy, 6100);

        // ATX loss while running
        pressToRun();
        idleMs(50 + randBits(8));
        wrBase = wrPulses;
        ATX_PowerOK = 1'b0;
        waitState(PowerFail, 5);
        waitPs(PwrSwOff, 5);
        waitState(Wait2s, 5100);
        checkBit("stored bit", storedBit, PwrStateFail);
        checkInt("write pulses", wrPulses - wrBase, 0);
        waitState(PowerStandBy, 6100);

        // Reset with Fail stored and power good never coming
        ATX_PowerOK = 1'b1;
        ALL_PWRGD = 1'b0;
        applyReset();
        checkBit("PwrLastStateWrBit", PwrLastStateWrBit, PwrStateOk);
        waitState(Reboot, 200);
        checkBit("PwrLastStateWrBit", PwrLastStateWrBit, PwrStateFail);
        waitPs(PwrSwOn, 5);
        onMs = 0;
        while (PS_ONn === PwrSwOn && onMs < 5100 * CycMs) begin
            tick();
            onMs++;
        end
        onMs = onMs / CycMs;
        if (onMs < 4990 || onMs > 5010) begin
            $display("error at %0t: PS_ONn on for %0d ms, expected 5000", $time, onMs);
            scenErrors++;
        end
        waitState(Wait2s, 5);
        checkInt("write pulses", wrPulses - wrBase, 0);
        waitState(PowerStandBy, 6100);

        $display("Errors: scenario %0d, checker %0d", scenErrors, chkErrors);
        if (scenErrors + chkErrors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* pwrEvent.f */
verilog/pwrEventPkg.sv
verilog/msTimer.sv
verilog/promSequencer.sv
verilog/pwrEventFsm.sv
verilog/pwrEventTop.sv
verification/pwrEventChecker.sv
verification/tbPwrEvent.sv
